// File: Makefile
TOP := trap_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)
	verilator --lint-only -f verilog.f --top-module trap_unit_top \
		design/trap_pkg.sv

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: design/exc_controller.sv
/////////////////////
// exception controller
// ranks trap events, picks cause and target code
// holds the request until the sequencer acks
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module exc_controller #(
  parameter bit user_mode_en = 1'b1
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // decoder strobes
  input  logic                                ebrk_insn_i,
  input  logic                                ecall_insn_i,
  input  logic                                illegal_insn_i,
  // level interrupt
  input  logic                                irq_i,
  input  logic [4:0]                          irq_id_i,
  input  logic                                irq_enable_i,
  input  logic [31:0]                         pc_i,
  input  trap_pkg::priv_lvl_t                 priv_lvl_i,
  input  logic [trap_pkg::dbg_sets_w-1:0]     dbg_settings_i,
  // handshake with the sequencer
  input  logic                                ack_i,
  output logic                                int_req_o,
  output logic                                ext_req_o,
  output logic                                save_cause_o,
  output logic [5:0]                          cause_o,
  output logic [1:0]                          pc_mux_o,
  output logic [31:0]                         epc_o,
  output logic                                dbg_trap_o
);

  typedef enum logic [1:0] {st_idle, st_wait_int, st_wait_ext} ctrl_state_t;

  ctrl_state_t state_q, state_d;

  logic        exc_any;
  logic        irq_valid;
  logic [5:0]  cause_int;
  logic [1:0]  pc_mux_int;
  // captured at the first request cycle
  logic [5:0]  cause_q;
  logic [1:0]  pc_mux_q;
  logic [31:0] epc_q;

  // debug trap, purely combinational
  // single step forces it regardless of the event
  assign dbg_trap_o = dbg_settings_i[trap_pkg::dbg_sets_sste]
                    | (ecall_insn_i   & dbg_settings_i[trap_pkg::dbg_sets_ecall])
                    | (ebrk_insn_i    & dbg_settings_i[trap_pkg::dbg_sets_ebrk])
                    | (illegal_insn_i & dbg_settings_i[trap_pkg::dbg_sets_eill])
                    | (irq_enable_i & irq_i & dbg_settings_i[trap_pkg::dbg_sets_irq]);

  assign exc_any   = ebrk_insn_i | ecall_insn_i | illegal_insn_i;
  // interrupt only counts with mie set
  assign irq_valid = irq_i & irq_enable_i;

  /////////////////////
  // event ranking
  /////////////////////
  // ebreak, ecall, illegal, then interrupt
  always_comb begin
    cause_int  = '0;
    pc_mux_int = trap_pkg::exc_pc_exc;
    if (ebrk_insn_i) begin
      cause_int = trap_pkg::cause_breakpoint;
    end else if (ecall_insn_i) begin
      // ecall cause follows the mode it was issued from
      if (user_mode_en && priv_lvl_i == trap_pkg::priv_lvl_u) begin
        cause_int = trap_pkg::cause_ecall_umode;
      end else begin
        cause_int = trap_pkg::cause_ecall_mmode;
      end
    end else if (illegal_insn_i) begin
      cause_int = trap_pkg::cause_illegal_insn;
    end else if (irq_valid) begin
      cause_int  = {1'b1, irq_id_i};
      pc_mux_int = trap_pkg::exc_pc_irq;
    end
  end

  // capture cause, target and pc on a new request
  always_ff @(posedge clk) begin
    if (state_q == st_idle && (exc_any || irq_valid)) begin
      cause_q  <= cause_int;
      pc_mux_q <= pc_mux_int;
      epc_q    <= pc_i;
    end
  end

  // bypass in idle, latched copy while waiting
  assign cause_o  = (state_q == st_idle) ? cause_int  : cause_q;
  assign pc_mux_o = (state_q == st_idle) ? pc_mux_int : pc_mux_q;
  assign epc_o    = (state_q == st_idle) ? pc_i       : epc_q;

  /////////////////////
  // request fsm
  /////////////////////
  always_comb begin
    state_d      = state_q;
    int_req_o    = 1'b0;
    ext_req_o    = 1'b0;
    save_cause_o = 1'b0;
    case (state_q)
      st_idle: begin
        int_req_o = exc_any;
        ext_req_o = ~exc_any & irq_valid;
        if (exc_any) begin
          state_d = st_wait_int;
        end else if (irq_valid) begin
          state_d = st_wait_ext;
        end
        // same-cycle ack completes at once
        if ((exc_any || irq_valid) && ack_i) begin
          save_cause_o = 1'b1;
          state_d      = st_idle;
        end
      end
      st_wait_int: begin
        int_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = st_idle;
        end
      end
      st_wait_ext: begin
        ext_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: design/handler_pc_gen.sv
/////////////////////
// handler address generator
// next fetch address for trap entry and mret
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module handler_pc_gen (
  input  logic [1:0]  pc_sel_i,
  input  logic [5:0]  cause_i,
  input  logic [31:0] mtvec_i,
  input  logic [31:0] mepc_i,
  output logic [31:0] handler_pc_o
);

  logic [31:0] base;
  logic [31:0] vec_offset;

  // mode bits dropped from the base
  assign base       = {mtvec_i[31:2], 2'b00};
  // four bytes per interrupt id
  assign vec_offset = {25'b0, cause_i[4:0], 2'b00};

  always_comb begin
    case (pc_sel_i)
      trap_pkg::exc_pc_exc: begin
        handler_pc_o = base;
      end
      trap_pkg::exc_pc_irq: begin
        // vectored only with mode bit set
        if (mtvec_i[0] && cause_i[5]) begin
          handler_pc_o = base + vec_offset;
        end else begin
          handler_pc_o = base;
        end
      end
      trap_pkg::exc_pc_mret: begin
        handler_pc_o = mepc_i;
      end
      default: begin
        handler_pc_o = base;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/trap_csr.sv
/////////////////////
// trap csrs
// mstatus, mtvec, mepc, mcause and the privilege level
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_csr #(
  parameter bit user_mode_en = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  // software port
  input  logic                csr_we_i,
  input  logic [11:0]         csr_addr_i,
  input  logic [31:0]         csr_wdata_i,
  output logic [31:0]         csr_rdata_o,
  // trap updates
  input  logic                save_cause_i,
  input  logic [5:0]          cause_i,
  input  logic [31:0]         epc_i,
  input  logic                mret_restore_i,
  output logic [31:0]         mtvec_o,
  output logic [31:0]         mepc_o,
  output logic                irq_enable_o,
  output trap_pkg::priv_lvl_t priv_lvl_o
);

  logic                mie_q;
  logic                mpie_q;
  trap_pkg::priv_lvl_t mpp_q;
  trap_pkg::priv_lvl_t priv_q;
  logic [31:0]         mtvec_q;
  logic [31:0]         mepc_q;
  logic [5:0]          mcause_q;
  trap_pkg::priv_lvl_t mpp_wr;

  // only u and m are legal in mpp
  assign mpp_wr = (user_mode_en && csr_wdata_i[12:11] == 2'b00) ?
                  trap_pkg::priv_lvl_u : trap_pkg::priv_lvl_m;

  /////////////////////
  // csr updates
  /////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mpp_q    <= trap_pkg::priv_lvl_m;
      priv_q   <= trap_pkg::priv_lvl_m;
      mtvec_q  <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (save_cause_i) begin
      // trap entry, stack mie and privilege
      mcause_q <= cause_i;
      mepc_q   <= epc_i;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
      mpp_q    <= priv_q;
      priv_q   <= trap_pkg::priv_lvl_m;
    end else if (mret_restore_i) begin
      // return, unstack
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      priv_q <= mpp_q;
      mpp_q  <= user_mode_en ? trap_pkg::priv_lvl_u : trap_pkg::priv_lvl_m;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        trap_pkg::csr_mstatus: begin
          mie_q  <= csr_wdata_i[3];
          mpie_q <= csr_wdata_i[7];
          mpp_q  <= mpp_wr;
        end
        // bit 1 of mtvec reserved
        trap_pkg::csr_mtvec:  mtvec_q  <= {csr_wdata_i[31:2], 1'b0, csr_wdata_i[0]};
        trap_pkg::csr_mepc:   mepc_q   <= {csr_wdata_i[31:1], 1'b0};
        trap_pkg::csr_mcause: mcause_q <= {csr_wdata_i[31], csr_wdata_i[4:0]};
        default: ;
      endcase
    end
  end

  // combinational read, unknown addresses give zero
  always_comb begin
    case (csr_addr_i)
      trap_pkg::csr_mstatus: csr_rdata_o = {19'b0, mpp_q, 3'b0, mpie_q, 3'b0, mie_q, 3'b0};
      trap_pkg::csr_mtvec:   csr_rdata_o = mtvec_q;
      trap_pkg::csr_mepc:    csr_rdata_o = mepc_q;
      trap_pkg::csr_mcause:  csr_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      default:               csr_rdata_o = '0;
    endcase
  end

  assign mtvec_o      = mtvec_q;
  assign mepc_o       = mepc_q;
  assign irq_enable_o = mie_q;
  assign priv_lvl_o   = priv_q;

endmodule

`default_nettype wire

// File: design/trap_pkg.sv
/////////////////////
// trap package
// privilege, cause, select-code and csr constants for trap entry
/////////////////////

`default_nettype none

package trap_pkg;

  // privilege levels, no supervisor
  typedef enum logic [1:0] {
    priv_lvl_u = 2'b00,
    priv_lvl_m = 2'b11
  } priv_lvl_t;

  /////////////////////
  // cause codes
  /////////////////////
  // top bit marks an interrupt, low five bits the code or irq id
  localparam logic [5:0] cause_illegal_insn = 6'd2;
  localparam logic [5:0] cause_breakpoint   = 6'd3;
  localparam logic [5:0] cause_ecall_umode  = 6'd8;
  localparam logic [5:0] cause_ecall_mmode  = 6'd11;

  /////////////////////
  // target select codes
  /////////////////////
  localparam logic [1:0] exc_pc_exc  = 2'b01;
  localparam logic [1:0] exc_pc_irq  = 2'b10;
  localparam logic [1:0] exc_pc_mret = 2'b11;

  // machine csr addresses
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  /////////////////////
  // debug settings
  /////////////////////
  localparam int dbg_sets_w     = 5;
  // bit positions inside dbg_settings
  localparam int dbg_sets_irq   = 0;
  localparam int dbg_sets_eill  = 1;
  localparam int dbg_sets_ebrk  = 2;
  localparam int dbg_sets_ecall = 3;
  localparam int dbg_sets_sste  = 4;

  // pipeline drain length before the trap is acknowledged
  localparam int flush_cycles = 2;

endpackage

`default_nettype wire

// File: design/trap_sequencer.sv
/////////////////////
// trap sequencer
// drains the pipeline for a fixed time, acks the trap
// and turns mret into a redirect
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_sequencer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       int_req_i,
  input  logic       ext_req_i,
  input  logic       mret_i,
  input  logic [1:0] pc_mux_i,
  output logic       ack_o,
  output logic       pc_set_o,
  output logic [1:0] pc_sel_o,
  output logic       mret_restore_o
);

  localparam int cnt_w = $clog2(trap_pkg::flush_cycles + 1);

  typedef enum logic {seq_idle, seq_drain} seq_state_t;

  seq_state_t       state_q;
  logic [cnt_w-1:0] cnt_q;
  logic             req;
  logic             drain_done;

  assign req        = int_req_i | ext_req_i;
  // count reaches the drain length in request cycle flush_cycles
  assign drain_done = (state_q == seq_drain) && (cnt_q == cnt_w'(trap_pkg::flush_cycles));

  /////////////////////
  // drain counter
  /////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= seq_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        seq_idle: begin
          // request cycle 0 seen here
          if (req) begin
            state_q <= seq_drain;
            cnt_q   <= cnt_w'(1);
          end
        end
        seq_drain: begin
          if (drain_done) begin
            state_q <= seq_idle;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + cnt_w'(1);
          end
        end
        default: begin
          state_q <= seq_idle;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  // single-cycle ack, request still held by the controller
  assign ack_o = drain_done & req;

  // mret only while idle, a new trap request wins
  assign mret_restore_o = (state_q == seq_idle) & mret_i & ~req;

  // redirect on trap entry or return
  assign pc_set_o = ack_o | mret_restore_o;
  assign pc_sel_o = mret_restore_o ? trap_pkg::exc_pc_mret : pc_mux_i;

endmodule

`default_nettype wire

// File: design/trap_unit_top.sv
/////////////////////
// trap unit top
// controller, sequencer, csrs and address generator
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_unit_top #(
  parameter bit user_mode_en = 1'b1
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            ebrk_insn_i,
  input  logic                            ecall_insn_i,
  input  logic                            illegal_insn_i,
  input  logic                            mret_i,
  input  logic                            irq_i,
  input  logic [4:0]                      irq_id_i,
  input  logic [31:0]                     pc_i,
  input  logic [trap_pkg::dbg_sets_w-1:0] dbg_settings_i,
  // software csr port
  input  logic                            csr_we_i,
  input  logic [11:0]                     csr_addr_i,
  input  logic [31:0]                     csr_wdata_i,
  output logic [31:0]                     csr_rdata_o,
  // redirect
  output logic                            pc_set_o,
  output logic [31:0]                     handler_pc_o,
  output logic                            trap_taken_o,
  output logic                            dbg_trap_o,
  output logic [5:0]                      cause_o,
  output trap_pkg::priv_lvl_t             priv_lvl_o
);

  // ack doubles as trap_taken_o
  logic        int_req;
  logic        ext_req;
  logic        save_cause;
  logic [1:0]  pc_mux;
  logic [1:0]  pc_sel;
  logic [31:0] epc;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic        irq_enable;
  logic        mret_restore;

  exc_controller #(.user_mode_en(user_mode_en)) exc_controller_i (
    .clk(clk), .rst_n(rst_n),
    .ebrk_insn_i(ebrk_insn_i), .ecall_insn_i(ecall_insn_i), .illegal_insn_i(illegal_insn_i),
    .irq_i(irq_i), .irq_id_i(irq_id_i), .irq_enable_i(irq_enable),
    .pc_i(pc_i), .priv_lvl_i(priv_lvl_o), .dbg_settings_i(dbg_settings_i),
    .ack_i(trap_taken_o), .int_req_o(int_req), .ext_req_o(ext_req),
    .save_cause_o(save_cause), .cause_o(cause_o), .pc_mux_o(pc_mux),
    .epc_o(epc), .dbg_trap_o(dbg_trap_o)
  );

  trap_sequencer trap_sequencer_i (
    .clk(clk), .rst_n(rst_n),
    .int_req_i(int_req), .ext_req_i(ext_req), .mret_i(mret_i), .pc_mux_i(pc_mux),
    .ack_o(trap_taken_o), .pc_set_o(pc_set_o), .pc_sel_o(pc_sel),
    .mret_restore_o(mret_restore)
  );

  trap_csr #(.user_mode_en(user_mode_en)) trap_csr_i (
    .clk(clk), .rst_n(rst_n),
    .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
    .save_cause_i(save_cause), .cause_i(cause_o), .epc_i(epc),
    .mret_restore_i(mret_restore), .csr_rdata_o(csr_rdata_o),
    .mtvec_o(mtvec), .mepc_o(mepc), .irq_enable_o(irq_enable), .priv_lvl_o(priv_lvl_o)
  );

  handler_pc_gen handler_pc_gen_i (
    .pc_sel_i(pc_sel), .cause_i(cause_o), .mtvec_i(mtvec), .mepc_i(mepc),
    .handler_pc_o(handler_pc_o)
  );

endmodule

`default_nettype wire

// File: dv/trap_unit_tb.sv
/////////////////////
// trap unit testbench
// replays the testdata operations and checks traps, mret and csrs
/////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb;

  localparam int max_ops      = 32;
  localparam int op_words     = 10;
  // request cycle that carries the ack
  localparam int drain_cycles = 2;

  logic        clk;
  logic        rst_n;
  logic        ebrk_insn_i;
  logic        ecall_insn_i;
  logic        illegal_insn_i;
  logic        mret_i;
  logic        irq_i;
  logic [4:0]  irq_id_i;
  logic [31:0] pc_i;
  logic [4:0]  dbg_settings_i;
  logic        csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        pc_set_o;
  logic [31:0] handler_pc_o;
  logic        trap_taken_o;
  logic        dbg_trap_o;
  logic [5:0]  cause_o;
  logic [1:0]  priv_lvl_o;

  logic [31:0] tdata [0:max_ops*op_words-1];
  logic [31:0] rng_state;
  int          cycle_cnt;
  int          cycle_limit;
  int          n_ops;

  trap_unit_top trap_unit_top_i (
    .clk(clk), .rst_n(rst_n),
    .ebrk_insn_i(ebrk_insn_i), .ecall_insn_i(ecall_insn_i),
    .illegal_insn_i(illegal_insn_i), .mret_i(mret_i),
    .irq_i(irq_i), .irq_id_i(irq_id_i), .pc_i(pc_i), .dbg_settings_i(dbg_settings_i),
    .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
    .csr_rdata_o(csr_rdata_o), .pc_set_o(pc_set_o), .handler_pc_o(handler_pc_o),
    .trap_taken_o(trap_taken_o), .dbg_trap_o(dbg_trap_o), .cause_o(cause_o),
    .priv_lvl_o(priv_lvl_o)
  );

  // 4 ns clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic clear_events();
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    ebrk_insn_i    = 1'b0;
    irq_i          = 1'b0;
    dbg_settings_i = '0;
  endtask

  task automatic drive_events(input logic [3:0] flags, input logic [4:0] id,
                              input logic [31:0] pc, input logic [4:0] dbg);
    illegal_insn_i = flags[0];
    ecall_insn_i   = flags[1];
    ebrk_insn_i    = flags[2];
    irq_i          = flags[3];
    irq_id_i       = id;
    pc_i           = pc;
    dbg_settings_i = dbg;
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    @(posedge clk);
    #1;
    csr_we_i = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    csr_addr_i = addr;
    #1;
    data = csr_rdata_o;
  endtask

  /////////////////////
  // trap entry
  /////////////////////
  task automatic run_trap(input logic [3:0] flags, input logic [4:0] id,
                          input logic [31:0] pc, input logic [4:0] dbg,
                          input logic exp_dbg, input logic [5:0] exp_cause,
                          input logic [31:0] exp_pc, input logic [31:0] exp_mepc,
                          input logic [1:0] exp_priv);
    int          cyc;
    logic [31:0] rd;
    @(posedge clk);
    #1;
    drive_events(flags, id, pc, dbg);
    #1;
    check_value("dbg_trap_o", 32'(dbg_trap_o), 32'(exp_dbg));
    cyc = 0;
    // strobes last one cycle, request is held by the dut
    while (pc_set_o !== 1'b1) begin
      if (cyc >= drain_cycles) begin
        stop_with("pc_set_o did not rise in the expected cycle after the trap event");
      end
      @(posedge clk);
      #1;
      clear_events();
      #1;
      cyc++;
    end
    if (cyc != drain_cycles) begin
      stop_with("pc_set_o rose before the pipeline drain was over");
    end
    check_value("trap_taken_o", 32'(trap_taken_o), 32'h1);
    check_value("cause_o", 32'(cause_o), 32'(exp_cause));
    check_value("handler_pc_o", handler_pc_o, exp_pc);
    read_csr(trap_pkg::csr_mepc, rd);
    check_value("mepc", rd, exp_mepc);
    read_csr(trap_pkg::csr_mcause, rd);
    // interrupt flag in bit 31, code in the low bits
    check_value("mcause", rd, {exp_cause[5], 31'(exp_cause[4:0])});
    read_csr(trap_pkg::csr_mstatus, rd);
    check_value("mstatus.mie", 32'(rd[3]), 32'h0);
    check_value("priv_lvl_o", 32'(priv_lvl_o), 32'(exp_priv));
  endtask

  // events that must not trap, checked over eight cycles
  task automatic run_no_trap(input logic [3:0] flags, input logic [4:0] id,
                             input logic [31:0] pc, input logic [4:0] dbg,
                             input logic exp_dbg);
    @(posedge clk);
    #1;
    drive_events(flags, id, pc, dbg);
    #1;
    check_value("dbg_trap_o", 32'(dbg_trap_o), 32'(exp_dbg));
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    repeat (8) begin
      @(posedge clk);
      #1;
      clear_events();
      #1;
      check_value("pc_set_o", 32'(pc_set_o), 32'h0);
      check_value("trap_taken_o", 32'(trap_taken_o), 32'h0);
    end
  endtask

  task automatic run_mret(input logic [31:0] exp_pc, input logic [1:0] exp_priv,
                          input logic exp_mie);
    logic [31:0] rd;
    @(posedge clk);
    #1;
    mret_i = 1'b1;
    #1;
    // redirect in the same cycle
    check_value("pc_set_o", 32'(pc_set_o), 32'h1);
    check_value("handler_pc_o", handler_pc_o, exp_pc);
    @(posedge clk);
    #1;
    mret_i = 1'b0;
    read_csr(trap_pkg::csr_mstatus, rd);
    check_value("mstatus.mie", 32'(rd[3]), 32'(exp_mie));
    check_value("priv_lvl_o", 32'(priv_lvl_o), 32'(exp_priv));
  endtask

  /////////////////////
  // main sequence
  /////////////////////
  initial begin
    logic [31:0] w [0:op_words-1];
    logic [4:0]  rid;
    rst_n          = 1'b0;
    mret_i         = 1'b0;
    irq_id_i       = '0;
    pc_i           = '0;
    csr_we_i       = 1'b0;
    csr_addr_i     = '0;
    csr_wdata_i    = '0;
    clear_events();
    cycle_cnt      = 0;
    cycle_limit    = 1000;
    rng_state      = 32'hcf9d5807;
    for (int i = 0; i < max_ops * op_words; i++) begin
      tdata[i] = '0;
    end
    $readmemh("dv/trap_unit_testdata.txt", tdata);
    n_ops = 0;
    while (n_ops < max_ops && tdata[n_ops*op_words] != 32'h0) begin
      n_ops++;
    end
    if (n_ops == 0) begin
      stop_with("no operations found in the test data file");
    end
    cycle_limit = n_ops * 8 + 20;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int op = 0; op < n_ops; op++) begin
      for (int k = 0; k < op_words; k++) begin
        w[k] = tdata[op*op_words+k];
      end
      case (w[0])
        32'h1: write_csr(w[1][11:0], w[3]);
        32'h2: run_trap(w[1][3:0], w[2][4:0], w[3], w[4][4:0], w[5][0], w[6][5:0],
                        w[7], w[8], w[9][1:0]);
        32'h3: run_mret(w[7], w[9][1:0], w[6][0]);
        32'h4: run_no_trap(w[1][3:0], w[2][4:0], w[3], w[4][4:0], w[5][0]);
        32'h5: begin
          // random interrupt id, vectored slot from the base column
          rng_state = xorshift(rng_state);
          rid       = rng_state[4:0];
          run_trap(4'b1000, rid, w[3], w[4][4:0], w[5][0], {1'b1, rid},
                   w[7] + 32'(rid) * 32'd4, w[8], w[9][1:0]);
        end
        default: stop_with("unknown operation code in the test data file");
      endcase
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/trap_unit_testdata.txt
// op flags(csr addr) irq_id pc(wdata) dbg exp_dbg exp_cause(mret mie) exp_pc mepc priv
// op 1 csr write, 2 trap, 3 mret, 4 no trap, 5 random irq; flags b0 ill b1 ecall b2 ebrk b3 irq
1 305 0 00001000 0 0 0 0 0 0
2 1 0 00000100 0 0 02 00001000 00000100 3
2 2 0 00000104 0 0 0b 00001000 00000104 3
2 4 0 00000108 0 0 03 00001000 00000108 3
2 3 0 0000010c 0 0 0b 00001000 0000010c 3
1 300 0 00000080 0 0 0 0 0 0
3 0 0 0 0 0 1 0000010c 0 0
2 2 0 00000200 0 0 08 00001000 00000200 3
1 305 0 00002001 0 0 0 0 0 0
1 300 0 00000008 0 0 0 0 0 0
2 8 5 00000300 0 0 25 00002014 00000300 3
1 300 0 00000008 0 0 0 0 0 0
2 c 3 00000304 4 1 03 00002000 00000304 3
4 8 7 00000308 1 0 0 0 0 0
1 300 0 00000008 0 0 0 0 0 0
5 0 0 00000400 1 1 0 00002000 00000400 3
1 300 0 00000008 0 0 0 0 0 0
5 0 0 00000404 1 1 0 00002000 00000404 3
4 0 0 00000408 10 1 0 0 0 0
2 1 0 00000408 2 1 02 00002000 00000408 3
2 2 0 0000040c 8 1 0b 00002000 0000040c 3
3 0 0 0 0 0 0 0000040c 0 3
0 0 0 0 0 0 0 0 0 0

// File: verilog.f
design/trap_pkg.sv
design/exc_controller.sv
design/trap_sequencer.sv
design/trap_csr.sv
design/handler_pc_gen.sv
design/trap_unit_top.sv
dv/trap_unit_tb.sv
